//--- img_pkg.sv
package img_pkg;

    // ===================================================================
    // Image geometry
    // ===================================================================
    localparam int img_width   = 16;
    localparam int img_height  = 8;
    localparam int pixel_count = img_width * img_height;
    localparam int col_bits    = $clog2(img_width);
    localparam int row_bits    = $clog2(img_height);

    // Sensor and buffer words
    localparam int pixel_bits = 12;
    localparam int word_bits  = 16;
    localparam int addr_bits  = $clog2(pixel_count);

    // ===================================================================
    // Readout framing
    // ===================================================================
    localparam int header_words  = 4;
    localparam int header_bits   = header_words * word_bits;
    localparam int padding_words = 2;
    localparam int csum_words    = 2;
    // Checksum words followed by zero padding
    localparam int tail_words    = csum_words + padding_words;
    localparam int shift_count_bits =
        $clog2((header_words > tail_words ? header_words : tail_words) + 1);

    // Thumbnail keeps the leading 2x2 corner of every 8x8 group
    localparam int thumb_group = 8;
    localparam int thumb_keep  = 2;

    // ===================================================================
    // Capture statistics
    // ===================================================================
    localparam int stat_bits  = 18;
    localparam int count_bits = 8;
    localparam int stat_grid  = 4;
    localparam int code_bits  = 7;
    localparam logic [code_bits-1:0] highlight_code = '1;
    localparam logic [code_bits-1:0] shadow_code    = '0;

endpackage

//--- fletcher_checksum.sv
`timescale 1ns/1ns

module fletcher_checksum (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clear,
    input  logic                              add,
    input  logic [img_pkg::word_bits-1:0]     din,
    output logic [2*img_pkg::word_bits-1:0]   sum
);

    logic [img_pkg::word_bits-1:0] sum_a;
    logic [img_pkg::word_bits-1:0] sum_b;
    logic [img_pkg::word_bits-1:0] next_a;

    // Add modulo 2^n-1 with both operands already reduced
    function automatic logic [img_pkg::word_bits-1:0] mod_add(
        input logic [img_pkg::word_bits-1:0] x,
        input logic [img_pkg::word_bits-1:0] y
    );
        logic [img_pkg::word_bits:0] t;
        t = x + y;
        if (t >= {1'b0, {img_pkg::word_bits{1'b1}}})
            t = t - {1'b0, {img_pkg::word_bits{1'b1}}};
        return t[img_pkg::word_bits-1:0];
    endfunction

    always_comb next_a = mod_add(sum_a, din);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (add) begin
            sum_a <= next_a;
            sum_b <= mod_add(sum_b, next_a);
        end
    end

    assign sum = {sum_b, sum_a};

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer (
    input  logic                            clk,
    input  logic                            wr_en,
    input  logic [img_pkg::addr_bits-1:0]   wr_addr,
    input  logic [img_pkg::word_bits-1:0]   wr_data,
    input  logic                            rd_en,
    input  logic [img_pkg::addr_bits-1:0]   rd_addr,
    output logic [img_pkg::word_bits-1:0]   rd_data
);

    // One word per pixel of the frame
    logic [img_pkg::word_bits-1:0] mem [img_pkg::pixel_count];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered read, data holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

//--- pixel_capture.sv
`timescale 1ns/1ns

module pixel_capture (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [img_pkg::pixel_bits-1:0]     img_d,
    input  logic                               img_fv,
    input  logic                               img_lv,
    input  logic                               cmd_capture,
    output logic                               wr_en,
    output logic [img_pkg::addr_bits-1:0]      wr_addr,
    output logic [img_pkg::word_bits-1:0]      wr_data,
    output logic                               status_capture_done,
    output logic [img_pkg::count_bits-1:0]     status_pixel_count,
    output logic [img_pkg::stat_bits-1:0]      status_highlight_count,
    output logic [img_pkg::stat_bits-1:0]      status_shadow_count
);

    typedef enum logic [1:0] {
        cap_idle,
        cap_armed,
        cap_run
    } cap_state_t;

    cap_state_t                        state;
    logic [img_pkg::pixel_bits-1:0]    d_r;
    logic                              fv_r;
    logic                              lv_r;
    logic                              fv_prev;
    logic                              lv_prev;
    logic [img_pkg::col_bits-1:0]      col;
    logic [img_pkg::row_bits-1:0]      row;
    logic                              frame_start;
    logic                              pixel_in;
    logic                              sample_point;
    logic [img_pkg::code_bits-1:0]     top_bits;

    // ===================================================================
    // Sensor port sampling
    // ===================================================================
    always_ff @(posedge clk) begin
        d_r <= img_d;
        if (reset) begin
            fv_r    <= 1'b0;
            lv_r    <= 1'b0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_r    <= img_fv;
            lv_r    <= img_lv;
            fv_prev <= fv_r;
            lv_prev <= lv_r;
        end
    end

    // Column within the line, row bumps at each line end
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else begin
            if (!lv_r)
                col <= '0;
            else
                col <= col + 1'b1;

            if (!fv_r)
                row <= '0;
            else if (lv_prev && !lv_r)
                row <= row + 1'b1;
        end
    end

    always_comb begin
        frame_start  = fv_r && !fv_prev;
        pixel_in     = (state == cap_run) && fv_r && lv_r &&
                       (status_pixel_count < img_pkg::pixel_count);
        sample_point = ((col % img_pkg::stat_grid) == 0) &&
                       ((row % img_pkg::stat_grid) == 0);
        top_bits     = d_r[img_pkg::pixel_bits-1 -: img_pkg::code_bits];
    end

    // ===================================================================
    // Capture FSM and statistics
    // ===================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state                  <= cap_idle;
            wr_en                  <= 1'b0;
            status_capture_done    <= 1'b0;
            status_pixel_count     <= '0;
            status_highlight_count <= '0;
            status_shadow_count    <= '0;
        end else begin
            wr_en               <= pixel_in;
            status_capture_done <= 1'b0;

            if (pixel_in) begin
                status_pixel_count <= status_pixel_count + 1'b1;
                if (sample_point && top_bits == img_pkg::highlight_code)
                    status_highlight_count <= status_highlight_count + 1'b1;
                if (sample_point && top_bits == img_pkg::shadow_code)
                    status_shadow_count <= status_shadow_count + 1'b1;
            end

            case (state)
                cap_idle: begin
                    if (cmd_capture) begin
                        status_pixel_count     <= '0;
                        status_highlight_count <= '0;
                        status_shadow_count    <= '0;
                        state                  <= cap_armed;
                    end
                end
                cap_armed: begin
                    if (frame_start)
                        state <= cap_run;
                end
                cap_run: begin
                    // Frame valid dropped, frame complete
                    if (!fv_r) begin
                        status_capture_done <= 1'b1;
                        state               <= cap_idle;
                    end
                end
                default: state <= cap_idle;
            endcase
        end
    end

    // Pixel word, zero-extended, written at the running count
    always_ff @(posedge clk) begin
        if (pixel_in) begin
            wr_addr <= status_pixel_count[img_pkg::addr_bits-1:0];
            wr_data <= {{(img_pkg::word_bits - img_pkg::pixel_bits){1'b0}}, d_r};
        end
    end

endmodule

//--- readout_streamer.sv
`timescale 1ns/1ns

module readout_streamer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cmd_readout,
    input  logic [img_pkg::header_bits-1:0]   cmd_header,
    input  logic                              cmd_thumb,
    output logic                              readout_start,
    output logic                              readout_ready,
    input  logic                              readout_trigger,
    output logic [img_pkg::word_bits-1:0]     readout_data,
    output logic                              readout_done,
    output logic                              rd_en,
    output logic [img_pkg::addr_bits-1:0]     rd_addr,
    input  logic [img_pkg::word_bits-1:0]     rd_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_shift,
        st_pix_req,
        st_pix_data,
        st_csum
    } st_t;

    st_t                                     state;
    logic [img_pkg::header_bits-1:0]         shift_reg;
    logic [img_pkg::shift_count_bits-1:0]    shift_count;
    logic                                    shift_tail;
    logic                                    thumb;
    logic [img_pkg::col_bits-1:0]            col;
    logic [img_pkg::row_bits-1:0]            row;
    logic [img_pkg::addr_bits-1:0]           pix_addr;
    logic                                    csum_add;
    logic                                    csum_clear;
    logic [2*img_pkg::word_bits-1:0]         csum;
    logic                                    load;
    logic                                    keep;

    fletcher_checksum u_checksum (
        .clk   (clk),
        .reset (reset),
        .clear (csum_clear),
        .add   (csum_add),
        .din   (readout_data),
        .sum   (csum)
    );

    // Output register free or being drained this cycle
    always_comb begin
        load = !readout_ready || readout_trigger;
        keep = !thumb ||
               (((col % img_pkg::thumb_group) < img_pkg::thumb_keep) &&
                ((row % img_pkg::thumb_group) < img_pkg::thumb_keep));
    end

    // No buffer read while a presented word is still waiting
    assign rd_en   = (state == st_pix_req) && load;
    assign rd_addr = pix_addr;

    // ===================================================================
    // Readout FSM
    // ===================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            readout_ready <= 1'b0;
            readout_start <= 1'b0;
            readout_done  <= 1'b1;
            csum_add      <= 1'b0;
            csum_clear    <= 1'b0;
            shift_count   <= '0;
            shift_tail    <= 1'b0;
        end else begin
            readout_start <= 1'b0;
            csum_clear    <= 1'b0;
            csum_add      <= 1'b0;
            if (readout_ready && readout_trigger)
                readout_ready <= 1'b0;

            case (state)
                st_idle: begin
                    if (cmd_readout) begin
                        readout_done  <= 1'b0;
                        readout_start <= 1'b1;
                        csum_clear    <= 1'b1;
                        thumb         <= cmd_thumb;
                        shift_reg     <= cmd_header;
                        shift_count   <= img_pkg::shift_count_bits'(img_pkg::header_words);
                        shift_tail    <= 1'b0;
                        col           <= '0;
                        row           <= '0;
                        pix_addr      <= '0;
                        state         <= st_shift;
                    end
                end

                // Header or checksum words, most significant first
                st_shift: begin
                    if (load) begin
                        if (shift_count != 0) begin
                            readout_data  <= shift_reg[img_pkg::header_bits-1 -:
                                                       img_pkg::word_bits];
                            readout_ready <= 1'b1;
                            csum_add      <= !shift_tail;
                            shift_reg     <= shift_reg << img_pkg::word_bits;
                            shift_count   <= shift_count - 1'b1;
                        end else if (shift_tail) begin
                            readout_done <= 1'b1;
                            state        <= st_idle;
                        end else begin
                            state <= st_pix_req;
                        end
                    end
                end

                st_pix_req: begin
                    if (load)
                        state <= st_pix_data;
                end

                // Output register is empty here, rd_data is fresh
                st_pix_data: begin
                    if (keep) begin
                        readout_data  <= rd_data;
                        readout_ready <= 1'b1;
                        csum_add      <= 1'b1;
                    end
                    if (col == img_pkg::img_width - 1) begin
                        col <= '0;
                        row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                    pix_addr <= pix_addr + 1'b1;
                    if (pix_addr == img_pkg::pixel_count - 1)
                        state <= st_csum;
                    else
                        state <= st_pix_req;
                end

                // Wait for the last pixel to land in the sums
                st_csum: begin
                    if (!csum_add) begin
                        shift_reg   <= {csum, {(img_pkg::header_bits -
                                               2*img_pkg::word_bits){1'b0}}};
                        shift_count <= img_pkg::shift_count_bits'(img_pkg::tail_words);
                        shift_tail  <= 1'b1;
                        state       <= st_shift;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- img_controller.sv
`timescale 1ns/1ns

module img_controller (
    input  logic                              clk,
    input  logic                              reset,
    // Sensor port
    input  logic [img_pkg::pixel_bits-1:0]    img_d,
    input  logic                              img_fv,
    input  logic                              img_lv,
    // Commands
    input  logic                              cmd_capture,
    input  logic                              cmd_readout,
    input  logic [img_pkg::header_bits-1:0]   cmd_header,
    input  logic                              cmd_thumb,
    // Status
    output logic                              status_capture_done,
    output logic [img_pkg::count_bits-1:0]    status_pixel_count,
    output logic [img_pkg::stat_bits-1:0]     status_highlight_count,
    output logic [img_pkg::stat_bits-1:0]     status_shadow_count,
    // Readout port
    output logic                              readout_start,
    output logic                              readout_ready,
    input  logic                              readout_trigger,
    output logic [img_pkg::word_bits-1:0]     readout_data,
    output logic                              readout_done
);

    logic                            wr_en;
    logic [img_pkg::addr_bits-1:0]   wr_addr;
    logic [img_pkg::word_bits-1:0]   wr_data;
    logic                            rd_en;
    logic [img_pkg::addr_bits-1:0]   rd_addr;
    logic [img_pkg::word_bits-1:0]   rd_data;

    pixel_capture u_capture (
        .clk                    (clk),
        .reset                  (reset),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .cmd_capture            (cmd_capture),
        .wr_en                  (wr_en),
        .wr_addr                (wr_addr),
        .wr_data                (wr_data),
        .status_capture_done    (status_capture_done),
        .status_pixel_count     (status_pixel_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    frame_buffer u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    readout_streamer u_streamer (
        .clk             (clk),
        .reset           (reset),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .readout_start   (readout_start),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .readout_done    (readout_done),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data)
    );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [img_pkg::pixel_bits-1:0]    frame [img_pkg::pixel_count],
    input  logic [img_pkg::header_bits-1:0]   cmd_header,
    input  logic                              cmd_thumb,
    input  logic                              readout_start,
    input  logic                              readout_ready,
    input  logic                              readout_trigger,
    input  logic [img_pkg::word_bits-1:0]     readout_data,
    input  logic                              readout_done,
    input  logic [img_pkg::count_bits-1:0]    status_pixel_count,
    input  logic [img_pkg::stat_bits-1:0]     status_highlight_count,
    input  logic [img_pkg::stat_bits-1:0]     status_shadow_count
);

    logic [img_pkg::word_bits-1:0] exp_q[$];
    int   word_idx      = 0;
    int   stream_errors = 0;
    int   check_errors  = 0;
    int   tests_run     = 0;
    int   tests_failed  = 0;
    int   test_mark     = 0;
    time  test_begin    = 0;
    time  last_start    = 0;
    logic in_stream     = 1'b0;
    logic done_prev     = 1'b1;

    // ===================================================================
    // Reference model
    // ===================================================================
    // Header MSW first, kept pixels, Fletcher sums, then zero padding
    function automatic void build_expected(input logic [img_pkg::header_bits-1:0] hdr,
                                           input logic thumb);
        int s1;
        int s2;
        int col;
        int row;
        s1 = 0;
        s2 = 0;
        exp_q.delete();
        for (int h = img_pkg::header_words - 1; h >= 0; h--)
            exp_q.push_back(hdr[h*img_pkg::word_bits +: img_pkg::word_bits]);
        for (int a = 0; a < img_pkg::pixel_count; a++) begin
            col = a % img_pkg::img_width;
            row = a / img_pkg::img_width;
            if (!thumb || ((col % img_pkg::thumb_group) < img_pkg::thumb_keep &&
                           (row % img_pkg::thumb_group) < img_pkg::thumb_keep))
                exp_q.push_back(img_pkg::word_bits'(frame[a]));
        end
        // Checksum covers everything queued so far
        foreach (exp_q[i]) begin
            s1 = (s1 + int'(exp_q[i])) % 65535;
            s2 = (s2 + s1) % 65535;
        end
        exp_q.push_back(16'(s2));
        exp_q.push_back(16'(s1));
        for (int p = 0; p < img_pkg::padding_words; p++)
            exp_q.push_back('0);
    endfunction

    // Sampled pixels on the stat grid whose top bits match a code
    function automatic int count_code(input logic [img_pkg::code_bits-1:0] code);
        int n;
        n = 0;
        for (int a = 0; a < img_pkg::pixel_count; a++) begin
            if ((a % img_pkg::img_width) % img_pkg::stat_grid == 0 &&
                (a / img_pkg::img_width) % img_pkg::stat_grid == 0 &&
                frame[a][img_pkg::pixel_bits-1 -: img_pkg::code_bits] == code)
                n++;
        end
        return n;
    endfunction

    // ===================================================================
    // Stream monitor
    // ===================================================================
    always @(posedge clk) begin
        if (reset) begin
            in_stream = 1'b0;
            word_idx  = 0;
        end else begin
            if (readout_start) begin
                build_expected(cmd_header, cmd_thumb);
                last_start = $time;
                word_idx   = 0;
                in_stream  = 1'b1;
            end
            if (readout_ready && readout_trigger) begin
                if (!in_stream) begin
                    $display("Word %h consumed with no readout_start before it", readout_data);
                    stream_errors++;
                end else if (word_idx >= exp_q.size()) begin
                    $display("Extra word %h consumed after the end of the stream",
                             readout_data);
                    stream_errors++;
                end else if (readout_data !== exp_q[word_idx]) begin
                    $display("ERROR at %0t: readout_data word %0d expected %h actual %h",
                             $time, word_idx, exp_q[word_idx], readout_data);
                    stream_errors++;
                end
                word_idx++;
            end
            if (readout_done && !done_prev)
                in_stream = 1'b0;
        end
        done_prev = readout_done;
    end

    // ===================================================================
    // Checks called between tests
    // ===================================================================
    function automatic int total_errors();
        return stream_errors + check_errors;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic begin_test();
        test_begin = $time;
        test_mark  = total_errors();
    endtask

    task automatic check_pixel_count();
        compare_value("status_pixel_count", img_pkg::pixel_count, int'(status_pixel_count));
    endtask

    task automatic check_stats();
        compare_value("status_highlight_count", count_code(img_pkg::highlight_code),
                      int'(status_highlight_count));
        compare_value("status_shadow_count", count_code(img_pkg::shadow_code),
                      int'(status_shadow_count));
    endtask

    task automatic check_stream_end();
        if (last_start <= test_begin) begin
            $display("No readout_start pulse was seen for this readout");
            check_errors++;
        end
        compare_value("readout word count", exp_q.size(), word_idx);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() != test_mark) begin
            tests_failed++;
            $display("Test %0d %s: fail, %0d errors", tests_run, name,
                     total_errors() - test_mark);
        end else begin
            $display("Test %0d %s: ok", tests_run, name);
        end
    endtask

    task automatic report();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
    endtask

endmodule

//--- tb_img_controller.sv
`timescale 1ns/1ns

module tb_img_controller;

    localparam int cap_timeout  = 1000;
    localparam int read_timeout = 2000;

    logic                              clk;
    logic                              reset;
    logic [img_pkg::pixel_bits-1:0]    img_d;
    logic                              img_fv;
    logic                              img_lv;
    logic                              cmd_capture;
    logic                              cmd_readout;
    logic [img_pkg::header_bits-1:0]   cmd_header;
    logic                              cmd_thumb;
    logic                              status_capture_done;
    logic [img_pkg::count_bits-1:0]    status_pixel_count;
    logic [img_pkg::stat_bits-1:0]     status_highlight_count;
    logic [img_pkg::stat_bits-1:0]     status_shadow_count;
    logic                              readout_start;
    logic                              readout_ready;
    logic                              readout_trigger;
    logic [img_pkg::word_bits-1:0]     readout_data;
    logic                              readout_done;

    // Recorded frame, read by the checker
    logic [img_pkg::pixel_bits-1:0]    frame [img_pkg::pixel_count];
    int                                seed      = 32'h8dff;
    logic                              random_bp = 1'b0;

    img_controller u_dut (
        .clk                    (clk),
        .reset                  (reset),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .cmd_capture            (cmd_capture),
        .cmd_readout            (cmd_readout),
        .cmd_header             (cmd_header),
        .cmd_thumb              (cmd_thumb),
        .status_capture_done    (status_capture_done),
        .status_pixel_count     (status_pixel_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count),
        .readout_start          (readout_start),
        .readout_ready          (readout_ready),
        .readout_trigger        (readout_trigger),
        .readout_data           (readout_data),
        .readout_done           (readout_done)
    );

    tb_checker u_checker (
        .clk                    (clk),
        .reset                  (reset),
        .frame                  (frame),
        .cmd_header             (cmd_header),
        .cmd_thumb              (cmd_thumb),
        .readout_start          (readout_start),
        .readout_ready          (readout_ready),
        .readout_trigger        (readout_trigger),
        .readout_data           (readout_data),
        .readout_done           (readout_done),
        .status_pixel_count     (status_pixel_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Consumer, full throughput or random back-pressure
    initial begin
        int r;
        readout_trigger = 1'b1;
        forever begin
            @(negedge clk);
            if (random_bp) begin
                r               = $random(seed);
                readout_trigger = r[0];
            end else begin
                readout_trigger = 1'b1;
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic wait_capture_done();
        for (int i = 0; i < cap_timeout; i++) begin
            @(negedge clk);
            if (status_capture_done)
                return;
        end
        abort_on_timeout("capture never pulsed status_capture_done");
    endtask

    // Done must drop first, then rise again at the end of the stream
    task automatic wait_readout_done();
        logic started;
        started = 1'b0;
        for (int i = 0; i < read_timeout; i++) begin
            if (!readout_done)
                started = 1'b1;
            else if (started)
                return;
            @(negedge clk);
        end
        abort_on_timeout("readout never finished with readout_done high");
    endtask

    // ===================================================================
    // Sensor frame generator
    // ===================================================================
    task automatic capture_frame();
        logic [img_pkg::pixel_bits-1:0] pix;
        int                             r;
        @(negedge clk);
        cmd_capture = 1'b1;
        @(negedge clk);
        cmd_capture = 1'b0;
        repeat (2) @(negedge clk);
        img_fv = 1'b1;
        repeat (3) @(negedge clk);
        for (int row = 0; row < img_pkg::img_height; row++) begin
            for (int col = 0; col < img_pkg::img_width; col++) begin
                r   = $random(seed);
                pix = r[img_pkg::pixel_bits-1:0];
                // Plant codes at some sample points
                if (col % img_pkg::stat_grid == 0 && row % img_pkg::stat_grid == 0) begin
                    if (r[13:12] == 2'd0)
                        pix[img_pkg::pixel_bits-1 -: img_pkg::code_bits] =
                            img_pkg::highlight_code;
                    else if (r[13:12] == 2'd1)
                        pix[img_pkg::pixel_bits-1 -: img_pkg::code_bits] =
                            img_pkg::shadow_code;
                end
                frame[row * img_pkg::img_width + col] = pix;
                img_d  = pix;
                img_lv = 1'b1;
                @(negedge clk);
            end
            img_lv = 1'b0;
            img_d  = '0;
            repeat (2) @(negedge clk);
        end
        img_fv = 1'b0;
        wait_capture_done();
    endtask

    task automatic run_readout(input logic [img_pkg::header_bits-1:0] header,
                               input logic thumb, input logic bp);
        @(posedge clk);
        random_bp = bp;
        @(negedge clk);
        cmd_header  = header;
        cmd_thumb   = thumb;
        cmd_readout = 1'b1;
        @(negedge clk);
        cmd_readout = 1'b0;
        wait_readout_done();
    endtask

    // ===================================================================
    // Test sequence
    // ===================================================================
    initial begin
        reset       = 1'b1;
        img_d       = '0;
        img_fv      = 1'b0;
        img_lv      = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_header  = '0;
        cmd_thumb   = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        u_checker.begin_test();
        capture_frame();
        u_checker.check_pixel_count();
        run_readout(64'h1234_5678_9abc_def0, 1'b0, 1'b0);
        u_checker.check_stream_end();
        u_checker.end_test("capture and full readout");

        u_checker.begin_test();
        u_checker.check_stats();
        u_checker.end_test("highlight and shadow counts");

        u_checker.begin_test();
        run_readout(64'h0f0f_a5a5_5a5a_f0f0, 1'b1, 1'b0);
        u_checker.check_stream_end();
        u_checker.end_test("thumbnail readout");

        u_checker.begin_test();
        run_readout(64'h0123_4567_89ab_cdef, 1'b0, 1'b1);
        u_checker.check_stream_end();
        u_checker.end_test("readout under back-pressure");

        // New frame and header, statistics start from zero again
        u_checker.begin_test();
        capture_frame();
        u_checker.check_pixel_count();
        u_checker.check_stats();
        run_readout(64'hfedc_ba98_7654_3210, 1'b0, 1'b0);
        u_checker.check_stream_end();
        u_checker.end_test("second frame with new header");

        u_checker.report();
        if (u_checker.total_errors() == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sources.f
img_pkg.sv
fletcher_checksum.sv
frame_buffer.sv
pixel_capture.sv
readout_streamer.sv
img_controller.sv
tb_checker.sv
tb_img_controller.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_img_controller -Mdir obj_dir

run: build
	@out="$$(./obj_dir/Vtb_img_controller)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	verilator --lint-only -Wall img_pkg.sv fletcher_checksum.sv frame_buffer.sv \
		pixel_capture.sv readout_streamer.sv img_controller.sv --top-module img_controller

clean:
	rm -rf obj_dir
